// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_rv_pipeline -f build.f

sim:
	verilator --binary --timing --top-module tb_rv_pipeline -f build.f
	out=$$(./obj_dir/Vtb_rv_pipeline 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== build.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_hazard_if.sv
rv_fetch.sv
rv_decode.sv
rv_reg_file.sv
rv_hazard_unit.sv
rv_execute.sv
rv_mem_wb.sv
rv_pipeline.sv
rv_pipeline_properties.sv
tb_rv_pipeline.sv

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_isa_pkg::word_t      if_instr,
    input  rv_isa_pkg::word_addr_t if_pc,
    input  rv_isa_pkg::word_t      rd_data_a,
    input  rv_isa_pkg::word_t      rd_data_b,
    output rv_isa_pkg::reg_idx_t   rd_idx_a,
    output rv_isa_pkg::reg_idx_t   rd_idx_b,
    output logic                   branch_taken,
    output rv_isa_pkg::word_addr_t branch_target,
    output rv_pipe_pkg::id_ex_t    id_ex,
    rv_hazard_if.decode            haz
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    instr_fields_t f;
    logic          is_r;
    logic          is_i;
    logic          is_load;
    logic          is_store;
    logic          is_branch;
    logic          cmp_equal;
    word_t         imm_i;
    word_t         imm_s;
    word_t         imm_b;
    word_t         cmp_a;
    word_t         cmp_b;
    alu_op_e       alu_op;
    id_ex_t        id_ex_next;

    assign f         = instr_fields_t'(if_instr);
    assign is_r      = f.opcode == op_r_type;
    assign is_i      = f.opcode == op_i_type;
    assign is_load   = f.opcode == op_load;
    assign is_store  = f.opcode == op_store;
    assign is_branch = f.opcode == op_branch;

    assign rd_idx_a = f.rs1;
    assign rd_idx_b = f.rs2;

    assign haz.rs1       = f.rs1;
    assign haz.rs2       = f.rs2;
    assign haz.use_rs1   = is_r | is_i | is_load | is_store | is_branch;
    // store data is read again in mem, so only r-type and branches count
    assign haz.use_rs2   = is_r | is_branch;
    assign haz.is_branch = is_branch;

    // ------------------------------
    // immediates
    // ------------------------------
    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};

    always_comb begin
        alu_op = alu_nop;
        case (f.opcode)
            op_r_type, op_i_type: begin
                case (f.funct3)
                    f3_add_sub: alu_op = (is_r && f.funct7[5]) ? alu_sub : alu_add;
                    f3_slt:     alu_op = alu_slt;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    alu_op = alu_nop;
                endcase
            end
            op_load, op_store: alu_op = alu_add;
            default:           alu_op = alu_nop;
        endcase
    end

    // ------------------------------
    // branch resolution in id
    // ------------------------------
    assign cmp_a     = fwd_mux(haz.fwd_cmp_a, rd_data_a, haz.mem_alu_out, haz.wb_data);
    assign cmp_b     = fwd_mux(haz.fwd_cmp_b, rd_data_b, haz.mem_alu_out, haz.wb_data);
    assign cmp_equal = cmp_a == cmp_b;

    // a held branch waits with stale operands and must not redirect
    assign branch_taken = is_branch && !haz.hold_front &&
                          ((f.funct3 == f3_beq && cmp_equal) ||
                           (f.funct3 == f3_bne && !cmp_equal));
    assign branch_target = if_pc + imm_b[xlen-1:2];

    always_comb begin
        id_ex_next           = '0;
        id_ex_next.alu_op    = alu_op;
        id_ex_next.reg_write = is_r | is_i | is_load;
        id_ex_next.mem_read  = is_load;
        id_ex_next.mem_write = is_store;
        id_ex_next.rd        = is_store ? f.rs2 : f.rd;
        id_ex_next.rs1       = f.rs1;
        id_ex_next.rs2       = f.rs2;
        id_ex_next.use_rs2   = is_r;
        id_ex_next.op_a      = rd_data_a;
        id_ex_next.op_b      = is_r ? rd_data_b : (is_store ? imm_s : imm_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!haz.hold_back) begin
            id_ex <= haz.bubble_ex ? '0 : id_ex_next;
        end
    end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::id_ex_t  id_ex,
    output rv_pipe_pkg::ex_mem_t ex_mem,
    rv_hazard_if.execute         haz
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t diff;
    word_t alu_out;
    logic  less;

    assign haz.ex_rd        = id_ex.rd;
    assign haz.ex_reg_write = id_ex.reg_write;
    assign haz.ex_mem_read  = id_ex.mem_read;
    assign haz.ex_rs1       = id_ex.rs1;
    assign haz.ex_rs2       = id_ex.rs2;
    assign haz.ex_use_rs2   = id_ex.use_rs2;

    assign alu_a = fwd_mux(haz.fwd_ex_a, id_ex.op_a, haz.mem_alu_out, haz.wb_data);
    assign alu_b = fwd_mux(haz.fwd_ex_b, id_ex.op_b, haz.mem_alu_out, haz.wb_data);

    // slt from the subtractor sign, corrected when the operand signs differ
    assign diff = alu_a - alu_b;
    assign less = (alu_a[xlen-1] != alu_b[xlen-1]) ? alu_a[xlen-1] : diff[xlen-1];

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_out = alu_a + alu_b;
            alu_sub: alu_out = diff;
            alu_and: alu_out = alu_a & alu_b;
            alu_or:  alu_out = alu_a | alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_slt: alu_out = {{(xlen-1){1'b0}}, less};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!haz.hold_back) begin
            ex_mem.alu_out   <= alu_out;
            ex_mem.rd        <= id_ex.rd;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
        end
    end

endmodule

// ==== rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_isa_pkg::word_t      icache_rdata,
    input  logic                   branch_taken,
    input  rv_isa_pkg::word_addr_t branch_target,
    output rv_isa_pkg::word_addr_t icache_addr,
    output rv_isa_pkg::word_t      if_instr,
    output rv_isa_pkg::word_addr_t if_pc,
    rv_hazard_if.fetch             haz
);
    import rv_isa_pkg::*;

    word_addr_t pc;
    word_addr_t pc_next;

    assign icache_addr = pc;

    // taken branch redirects, otherwise next word
    assign pc_next = branch_taken ? branch_target : pc + 30'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            if_instr <= nop_instr;
            if_pc    <= '0;
        end else if (!haz.hold_front) begin
            pc    <= pc_next;
            if_pc <= pc;
            // squash the word fetched behind a taken branch
            if_instr <= branch_taken ? nop_instr : bus_swap(icache_rdata);
        end
    end

endmodule

// ==== rv_hazard_if.sv ====
`timescale 1ns/1ps

interface rv_hazard_if ();
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // id stage sources
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_rs1;
    logic     use_rs2;
    logic     is_branch;

    // ex stage
    reg_idx_t ex_rd;
    logic     ex_reg_write;
    logic     ex_mem_read;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    logic     ex_use_rs2;

    // mem and wb stages
    reg_idx_t mem_rd;
    logic     mem_reg_write;
    logic     mem_mem_read;
    word_t    mem_alu_out;
    reg_idx_t wb_rd;
    logic     wb_reg_write;
    word_t    wb_data;

    // controls
    logic     hold_front;
    logic     bubble_ex;
    logic     hold_back;
    fwd_sel_e fwd_cmp_a;
    fwd_sel_e fwd_cmp_b;
    fwd_sel_e fwd_ex_a;
    fwd_sel_e fwd_ex_b;

    modport fetch (input hold_front);

    modport decode (
        output rs1, rs2, use_rs1, use_rs2, is_branch,
        input  hold_front, bubble_ex, hold_back, fwd_cmp_a, fwd_cmp_b,
        input  mem_alu_out, wb_data
    );

    modport execute (
        output ex_rd, ex_reg_write, ex_mem_read, ex_rs1, ex_rs2, ex_use_rs2,
        input  hold_back, fwd_ex_a, fwd_ex_b, mem_alu_out, wb_data
    );

    modport mem_wb (
        output mem_rd, mem_reg_write, mem_mem_read, mem_alu_out,
        output wb_rd, wb_reg_write, wb_data,
        input  hold_back
    );

    modport hazard (
        input  rs1, rs2, use_rs1, use_rs2, is_branch,
        input  ex_rd, ex_reg_write, ex_mem_read, ex_rs1, ex_rs2, ex_use_rs2,
        input  mem_rd, mem_reg_write, mem_mem_read, wb_rd, wb_reg_write,
        output hold_front, bubble_ex, hold_back,
        output fwd_cmp_a, fwd_cmp_b, fwd_ex_a, fwd_ex_b
    );

endinterface

// ==== rv_hazard_unit.sv ====
`timescale 1ns/1ps

module rv_hazard_unit (
    input  logic         icache_stall,
    input  logic         dcache_stall,
    rv_hazard_if.hazard  haz
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic load_use;
    logic branch_hz;
    logic front_stall;

    // rd feeds one of the branch sources in id
    function automatic logic hits_branch_src(reg_idx_t rd);
        return rd != '0 && (rd == haz.rs1 || rd == haz.rs2);
    endfunction

    // mem wins over wb, x0 never forwards
    function automatic fwd_sel_e pick_fwd(reg_idx_t idx, logic used);
        if (used && idx != '0 && haz.mem_reg_write && haz.mem_rd == idx) begin
            return fwd_mem;
        end
        if (used && idx != '0 && haz.wb_reg_write && haz.wb_rd == idx) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    // ------------------------------
    // interlocks
    // ------------------------------
    always_comb begin
        load_use = haz.ex_mem_read && haz.ex_rd != '0 &&
                   ((haz.use_rs1 && haz.ex_rd == haz.rs1) ||
                    (haz.use_rs2 && haz.ex_rd == haz.rs2));
        // alu result in ex is not forwarded into id, a load in mem is not ready yet
        branch_hz = haz.is_branch &&
                    ((haz.ex_reg_write && !haz.ex_mem_read && hits_branch_src(haz.ex_rd)) ||
                     (haz.mem_reg_write && haz.mem_mem_read && hits_branch_src(haz.mem_rd)));
    end

    assign front_stall    = icache_stall | load_use | branch_hz;
    assign haz.hold_front = front_stall | dcache_stall;
    assign haz.bubble_ex  = front_stall & ~dcache_stall;
    assign haz.hold_back  = dcache_stall;

    // ------------------------------
    // forwarding selects
    // ------------------------------
    always_comb begin
        haz.fwd_cmp_a = pick_fwd(haz.rs1, 1'b1);
        haz.fwd_cmp_b = pick_fwd(haz.rs2, 1'b1);
        haz.fwd_ex_a  = pick_fwd(haz.ex_rs1, 1'b1);
        haz.fwd_ex_b  = pick_fwd(haz.ex_rs2, haz.ex_use_rs2);
    end

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-3:0] word_addr_t;
    typedef logic [4:0]      reg_idx_t;

    // base opcodes kept by this core
    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,
        op_i_type = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // r-type field layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // caches carry words with the byte order reversed
    function automatic word_t bus_swap(word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

// ==== rv_mem_wb.sv ====
`timescale 1ns/1ps

module rv_mem_wb (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_pipe_pkg::ex_mem_t   ex_mem,
    input  rv_isa_pkg::word_t      dcache_rdata,
    input  rv_isa_pkg::word_t      store_data,
    output logic                   dcache_ren,
    output logic                   dcache_wen,
    output rv_isa_pkg::word_addr_t dcache_addr,
    output rv_isa_pkg::word_t      dcache_wdata,
    output rv_isa_pkg::reg_idx_t   store_idx,
    output rv_pipe_pkg::mem_wb_t   wb,
    rv_hazard_if.mem_wb            haz
);
    import rv_isa_pkg::*;

    // ------------------------------
    // data cache drive
    // ------------------------------
    assign dcache_ren   = ex_mem.mem_read;
    assign dcache_wen   = ex_mem.mem_write;
    assign dcache_addr  = ex_mem.alu_out[xlen-1:2];
    // store register read in mem, bypass covers a value still in wb
    assign store_idx    = ex_mem.rd;
    assign dcache_wdata = bus_swap(store_data);

    assign haz.mem_rd        = ex_mem.rd;
    assign haz.mem_reg_write = ex_mem.reg_write;
    assign haz.mem_mem_read  = ex_mem.mem_read;
    assign haz.mem_alu_out   = ex_mem.alu_out;
    assign haz.wb_rd         = wb.rd;
    assign haz.wb_reg_write  = wb.reg_write;
    assign haz.wb_data       = wb.wb_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!haz.hold_back) begin
            wb.wb_data   <= ex_mem.mem_read ? bus_swap(dcache_rdata) : ex_mem.alu_out;
            wb.rd        <= ex_mem.rd;
            wb.reg_write <= ex_mem.reg_write;
        end
    end

endmodule

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    typedef enum logic [2:0] {
        alu_nop = 3'd0,
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_and = 3'd3,
        alu_or  = 3'd4,
        alu_xor = 3'd5,
        alu_slt = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    // ------------------------------
    // stage payloads
    // ------------------------------

    typedef struct packed {
        alu_op_e              alu_op;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        // store keeps its data register here
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        logic                 use_rs2;
        rv_isa_pkg::word_t    op_a;
        rv_isa_pkg::word_t    op_b;
    } id_ex_t;

    typedef struct packed {
        rv_isa_pkg::word_t    alu_out;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
    } ex_mem_t;

    typedef struct packed {
        rv_isa_pkg::word_t    wb_data;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
    } mem_wb_t;

    // operand source choice shared by branch compare and alu inputs
    function automatic rv_isa_pkg::word_t fwd_mux(fwd_sel_e sel,
                                                  rv_isa_pkg::word_t reg_value,
                                                  rv_isa_pkg::word_t mem_value,
                                                  rv_isa_pkg::word_t wb_value);
        case (sel)
            fwd_mem: return mem_value;
            fwd_wb:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

endpackage

// ==== rv_pipeline.sv ====
`timescale 1ns/1ps

module rv_pipeline (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   icache_stall,
    input  rv_isa_pkg::word_t      icache_rdata,
    input  logic                   dcache_stall,
    input  rv_isa_pkg::word_t      dcache_rdata,
    output rv_isa_pkg::word_addr_t icache_addr,
    output logic                   dcache_ren,
    output logic                   dcache_wen,
    output rv_isa_pkg::word_addr_t dcache_addr,
    output rv_isa_pkg::word_t      dcache_wdata
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t      if_instr;
    word_addr_t if_pc;
    logic       branch_taken;
    word_addr_t branch_target;
    reg_idx_t   rd_idx_a;
    reg_idx_t   rd_idx_b;
    reg_idx_t   store_idx;
    word_t      rd_data_a;
    word_t      rd_data_b;
    word_t      store_data;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    mem_wb_t    wb;

    rv_hazard_if haz ();

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .icache_rdata(icache_rdata),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .icache_addr(icache_addr), .if_instr(if_instr), .if_pc(if_pc), .haz(haz)
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .if_instr(if_instr), .if_pc(if_pc),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .id_ex(id_ex), .haz(haz)
    );

    rv_reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .store_idx(store_idx), .wb(wb),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .store_data(store_data)
    );

    rv_hazard_unit u_hazard_unit (
        .icache_stall(icache_stall), .dcache_stall(dcache_stall), .haz(haz)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .ex_mem(ex_mem), .haz(haz)
    );

    rv_mem_wb u_mem_wb (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .dcache_rdata(dcache_rdata),
        .store_data(store_data), .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata),
        .store_idx(store_idx), .wb(wb), .haz(haz)
    );

endmodule

// ==== rv_pipeline_properties.sv ====
`timescale 1ns/1ps

module rv_pipeline_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   icache_stall,
    input logic                   dcache_stall,
    input rv_isa_pkg::word_addr_t icache_addr,
    input logic                   dcache_ren,
    input logic                   dcache_wen,
    input rv_isa_pkg::word_addr_t dcache_addr,
    input rv_isa_pkg::word_t      dcache_wdata
);

    int violations = 0;

    // first edge out of reset sees an idle data port
    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !dcache_ren && !dcache_wen)
        else begin violations++; $error("data cache enabled right after reset"); end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcache_ren && dcache_wen))
        else begin violations++; $error("data cache read and write at once"); end

    // a stalled fetch keeps its address
    icache_hold: assert property (@(posedge clk) disable iff (!rst_n)
        icache_stall |=> $stable(icache_addr))
        else begin violations++; $error("icache address moved during stall"); end

    dcache_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_stall |=> $stable(dcache_addr) && $stable(dcache_wen) && $stable(dcache_wdata))
        else begin violations++; $error("dcache request moved during stall"); end

endmodule

// ==== rv_reg_file.sv ====
`timescale 1ns/1ps

module rv_reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rd_idx_a,
    input  rv_isa_pkg::reg_idx_t rd_idx_b,
    input  rv_isa_pkg::reg_idx_t store_idx,
    input  rv_pipe_pkg::mem_wb_t wb,
    output rv_isa_pkg::word_t    rd_data_a,
    output rv_isa_pkg::word_t    rd_data_b,
    output rv_isa_pkg::word_t    store_data
);
    import rv_isa_pkg::*;

    word_t regs [reg_count];

    // write-through, x0 is never written so it stays zero
    function automatic word_t read_port(reg_idx_t idx);
        if (wb.reg_write && wb.rd != '0 && wb.rd == idx) begin
            return wb.wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_a  = read_port(rd_idx_a);
        rd_data_b  = read_port(rd_idx_b);
        store_data = read_port(store_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.wb_data;
        end
    end

endmodule

// ==== tb_rv_pipeline.sv ====
`timescale 1ns/1ps

module tb_rv_pipeline;
    import rv_isa_pkg::*;

    localparam int cycle_limit = 3000;

    logic       clk;
    logic       rst_n        = 1'b0;
    logic       icache_stall = 1'b0;
    logic       dcache_stall = 1'b0;
    word_t      icache_rdata;
    word_t      dcache_rdata;
    word_addr_t icache_addr;
    logic       dcache_ren;
    logic       dcache_wen;
    word_addr_t dcache_addr;
    word_t      dcache_wdata;

    word_t      imem [64];
    word_t      dmem [256];
    word_addr_t exp_addr_q [$];
    word_t      exp_data_q [$];
    word_addr_t exp_load_q [$];
    logic       stall_en    = 1'b0;
    int         cycle_count = 0;
    int         load_pc     = 0;

    rv_pipeline uut (
        .clk(clk), .rst_n(rst_n), .icache_stall(icache_stall), .icache_rdata(icache_rdata),
        .dcache_stall(dcache_stall), .dcache_rdata(dcache_rdata), .icache_addr(icache_addr),
        .dcache_ren(dcache_ren), .dcache_wen(dcache_wen), .dcache_addr(dcache_addr),
        .dcache_wdata(dcache_wdata)
    );

    bind rv_pipeline rv_pipeline_properties props (
        .clk(clk), .rst_n(rst_n), .icache_stall(icache_stall), .dcache_stall(dcache_stall),
        .icache_addr(icache_addr), .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata)
    );

    // both caches answer in the same cycle, memories hold bus order data
    assign icache_rdata = bus_swap(imem[icache_addr[5:0]]);
    assign dcache_rdata = dmem[dcache_addr[7:0]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_addr(word_addr_t actual, word_addr_t expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s address %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_word(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s data %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, program did not finish",
                                cycle_limit));
        end
    end

    // one falling edge with stall draws and the data cache traffic
    task automatic next_cycle();
        @(negedge clk);
        if (stall_en) begin
            icache_stall = ($urandom % 4) == 0;
            dcache_stall = ($urandom % 5) == 0;
        end else begin
            icache_stall = 1'b0;
            dcache_stall = 1'b0;
        end
        // write lands on the coming rising edge unless the cache stalls
        if (rst_n && dcache_wen && !dcache_stall) begin
            dmem[dcache_addr[7:0]] = dcache_wdata;
            if (exp_addr_q.size() == 0) begin
                abort_run($sformatf("unexpected store to word %h", dcache_addr));
            end else begin
                check_addr(dcache_addr, exp_addr_q.pop_front(), "store");
                check_word(bus_swap(dcache_wdata), exp_data_q.pop_front(), "store");
            end
        end
        if (rst_n && dcache_ren && !dcache_stall) begin
            if (exp_load_q.size() == 0) begin
                abort_run($sformatf("unexpected load from word %h", dcache_addr));
            end else begin
                check_addr(dcache_addr, exp_load_q.pop_front(), "load");
            end
        end
    endtask

    // ------------------------------
    // program assembly
    // ------------------------------
    task automatic emit(word_t instr);
        imem[load_pc[5:0]] = instr;
        load_pc++;
    endtask

    task automatic r_op(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        emit({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_r_type});
    endtask

    task automatic i_op(logic [2:0] f3, int rd, int rs1, int imm);
        emit({imm[11:0], rs1[4:0], f3, rd[4:0], op_i_type});
    endtask

    task automatic lw_op(int rd, int rs1, int off);
        emit({off[11:0], rs1[4:0], 3'b010, rd[4:0], op_load});
    endtask

    task automatic sw_op(int rs2, int rs1, int off);
        emit({off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], op_store});
    endtask

    task automatic br_op(logic [2:0] f3, int rs1, int rs2, int off);
        emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch});
    endtask

    task automatic expect_store(word_addr_t addr, word_t value);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(value);
    endtask

    task automatic expect_load(word_addr_t addr);
        exp_load_q.push_back(addr);
    endtask

    task automatic preload(int idx, word_t value);
        dmem[idx] = bus_swap(value);
    endtask

    // reset, clear memories and queues
    task automatic begin_test(string name, logic with_stalls);
        $display("test %s", name);
        rst_n    = 1'b0;
        stall_en = with_stalls;
        load_pc  = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_load_q.delete();
        for (int i = 0; i < 64; i++) begin
            imem[i] = nop_instr;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {8'hd0, i[7:0], ~i[7:0], 8'h5a};
        end
    endtask

    // program ends on a branch to itself, then run until the last store
    task automatic run_program();
        br_op(f3_beq, 0, 0, 0);
        next_cycle();
        next_cycle();
        rst_n = 1'b1;
        while (exp_addr_q.size() > 0 || exp_load_q.size() > 0) begin
            next_cycle();
        end
        repeat (12) next_cycle();
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic load_alu_program();
        i_op(f3_add_sub, 1, 0, 5);
        i_op(f3_add_sub, 2, 0, -3);
        r_op(7'h00, f3_add_sub, 3, 1, 2);
        r_op(7'h20, f3_add_sub, 4, 3, 1);
        r_op(7'h00, f3_and, 5, 4, 1);
        r_op(7'h00, f3_or, 6, 5, 2);
        r_op(7'h00, f3_xor, 7, 6, 1);
        r_op(7'h00, f3_slt, 8, 2, 1);
        r_op(7'h00, f3_slt, 9, 1, 2);
        i_op(f3_slt, 10, 2, -2);
        i_op(f3_and, 11, 7, 'h0f0);
        i_op(f3_or, 12, 11, 'h00f);
        i_op(f3_xor, 13, 12, -1);
        for (int r = 13, off = 64; off <= 104; off += 4) begin
            sw_op(r, 0, off);
            r = (r == 13) ? 3 : r + 1;
        end
        expect_store(16, 32'hffff_ff00);
        expect_store(17, 32'h0000_0002);
        expect_store(18, 32'hffff_fffd);
        expect_store(19, 32'h0000_0005);
        expect_store(20, 32'hffff_fffd);
        expect_store(21, 32'hffff_fff8);
        expect_store(22, 32'h0000_0001);
        expect_store(23, 32'h0000_0000);
        expect_store(24, 32'h0000_0001);
        expect_store(25, 32'h0000_00f0);
        expect_store(26, 32'h0000_00ff);
    endtask

    task automatic alu_chain();
        begin_test("alu chain", 1'b0);
        load_alu_program();
        run_program();
    endtask

    task automatic load_use();
        begin_test("load use", 1'b0);
        preload(8, 32'h1234_5678);
        i_op(f3_add_sub, 1, 0, 16);
        lw_op(2, 0, 32);
        r_op(7'h00, f3_add_sub, 3, 2, 1);
        sw_op(3, 1, 20);
        sw_op(2, 0, 40);
        lw_op(4, 0, 32);
        sw_op(4, 0, 44);
        expect_load(8);
        expect_load(8);
        expect_store(9, 32'h1234_5688);
        expect_store(10, 32'h1234_5678);
        expect_store(11, 32'h1234_5678);
        run_program();
        // raw memory word keeps the bus byte order
        check_word(dmem[9], 32'h8856_3412, "bus order");
    endtask

    task automatic branch_directions();
        begin_test("branch directions", 1'b0);
        i_op(f3_add_sub, 1, 0, 7);
        i_op(f3_add_sub, 2, 0, 7);
        i_op(f3_add_sub, 3, 0, 1);
        br_op(f3_beq, 1, 2, 8);
        sw_op(3, 0, 0);
        sw_op(1, 0, 4);
        br_op(f3_bne, 1, 2, 8);
        sw_op(2, 0, 8);
        br_op(f3_bne, 1, 3, 8);
        sw_op(3, 0, 12);
        br_op(f3_beq, 1, 3, 8);
        sw_op(3, 0, 16);
        expect_store(1, 32'd7);
        expect_store(2, 32'd7);
        expect_store(4, 32'd1);
        run_program();
    endtask

    task automatic branch_hazards();
        begin_test("branch operand hazards", 1'b0);
        preload(8, 32'd5);
        preload(9, 32'd6);
        i_op(f3_add_sub, 1, 0, 3);
        i_op(f3_add_sub, 6, 0, 5);
        i_op(f3_add_sub, 2, 0, 3);
        // producer right before the branch
        br_op(f3_beq, 1, 2, 8);
        i_op(f3_add_sub, 5, 0, 99);
        sw_op(2, 0, 0);
        // load two slots ahead
        lw_op(3, 0, 32);
        i_op(f3_add_sub, 7, 0, 1);
        br_op(f3_beq, 3, 6, 8);
        sw_op(7, 0, 4);
        sw_op(3, 0, 8);
        // load directly ahead
        lw_op(4, 0, 36);
        br_op(f3_bne, 4, 6, 8);
        sw_op(7, 0, 12);
        sw_op(4, 0, 16);
        i_op(f3_add_sub, 8, 0, 5);
        br_op(f3_bne, 8, 6, 8);
        sw_op(8, 0, 20);
        sw_op(5, 0, 24);
        expect_load(8);
        expect_load(9);
        expect_store(0, 32'd3);
        expect_store(2, 32'd5);
        expect_store(4, 32'd6);
        expect_store(5, 32'd5);
        expect_store(6, 32'd0);
        run_program();
    endtask

    task automatic stalled_alu_chain();
        begin_test("alu chain with stalls", 1'b1);
        load_alu_program();
        run_program();
    endtask

    task automatic x0_writes();
        begin_test("x0 writes", 1'b0);
        i_op(f3_add_sub, 0, 0, 55);
        sw_op(0, 0, 28);
        i_op(f3_add_sub, 1, 0, 9);
        r_op(7'h00, f3_add_sub, 0, 1, 1);
        sw_op(0, 0, 32);
        r_op(7'h00, f3_add_sub, 0, 1, 1);
        r_op(7'h00, f3_add_sub, 2, 0, 1);
        sw_op(2, 0, 36);
        expect_store(7, 32'd0);
        expect_store(8, 32'd0);
        expect_store(9, 32'd9);
        run_program();
    endtask

    initial begin
        void'($urandom(32));
        alu_chain();
        load_use();
        branch_directions();
        branch_hazards();
        stalled_alu_chain();
        x0_writes();
        if (uut.props.violations == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("%0d assertion failures on the cache ports", uut.props.violations);
            $display("Verification failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule
